// ==== dds_top.f ====
hdl/dds_pkg.sv
hdl/dds_regs.sv
hdl/dds_phase_acc.sv
hdl/dds_wave_gen.sv
hdl/dds_top.sv
bench/dds_top_sva.sv
bench/dds_top_tb.sv

// ==== Makefile ====
# Verilator flow for the DDS generator
TOP        ?= dds_top_tb
FILELIST   ?= dds_top.f
VERILATOR  ?= verilator
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --timing --assert -Wno-fatal
LINT_FLAGS ?= -Wall --timing
SOURCES    := $(wildcard hdl/*.sv bench/*.sv)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides the result, a run that stops early has no pass line
sim: $(OBJ_DIR)/V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TB PASSED" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/dds_top_tb.sv ====
`timescale 1ns/10ps

module dds_top_tb import dds_pkg::*; ();

    localparam int          cycle_limit = 12000;  // ~10 bus phases of under 1000 cycles plus margin
    localparam logic [31:0] amp_steps [3]   = '{32'd0, 32'd64, 32'd511};
    localparam logic [31:0] phase_steps [4] = '{32'h400, 32'h800, 32'hC00, 32'h123};
    localparam logic [3:0]  wave_list [4]   = '{wave_sine, wave_square, wave_triangle, wave_saw};

    logic        sys_clk;
    logic        sys_rst_n;
    logic        cmd_valid;
    logic        cmd_ready;
    logic [31:0] cmd_addr;
    logic        cmd_read;
    logic [31:0] cmd_wdata;
    logic        rsp_valid;
    logic        rsp_ready;
    logic        rsp_err;
    logic [31:0] rsp_rdata;
    logic [7:0]  dac_data;

    integer      seed;
    int          dac_errors;
    int          bus_errors;
    int          cycles;

    // model state holds the value after the latest edge
    logic        model_live;
    logic [31:0] m_amp;
    logic [31:0] m_freq;
    logic [11:0] m_poff;
    logic [3:0]  m_wave;
    logic [31:0] m_acc;
    logic [11:0] m_phase;
    logic [11:0] s1_phase;  // what stage 1 saw
    logic [3:0]  s1_wave;
    logic [7:0]  m_dac;
    logic        m_pend;    // response slot full

    dds_top #(.phase_width(32), .table_bits(12)) i_dds_top (
        .sys_clk, .sys_rst_n,
        .cmd_valid, .cmd_ready, .cmd_addr, .cmd_read, .cmd_wdata,
        .rsp_valid, .rsp_ready, .rsp_err, .rsp_rdata,
        .dac_data
    );

    always #2 sys_clk = ~sys_clk;  // 4 ns period

    ////////////////////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////////////////////

    // shape from the top 8 phase bits followed by gain and offset binary
    function automatic logic [7:0] expected_code(input logic [11:0] ph, input logic [3:0] wave,
                                                 input logic [8:0] gain);
        int  p;
        int  idx;
        int  s;
        int  code;
        real ang;
        p   = int'(ph[11:4]);
        idx = ph[10] ? 63 - int'(ph[9:4]) : int'(ph[9:4]);  // quadrant mirror
        ang = (real'(idx) + 0.5) * 3.14159265358979 / 128.0;
        case (wave)
            wave_sine:     s = $rtoi(127.0 * $sin(ang) + 0.5) * (ph[11] ? -1 : 1);
            wave_square:   s = (p < 128) ? 127 : -127;
            wave_triangle: s = 127 - 2 * ((p < 128) ? 128 - p : p - 128);
            wave_saw:      s = p - 128;
            default:       s = 0;
        endcase
        if (s < -127) s = -127;
        code = 128 + ((s * int'(gain)) >>> 8);  // floor division
        if (code < 0) code = 0;
        if (code > 255) code = 255;
        return 8'(code);
    endfunction

    function automatic logic is_mapped(input logic [7:0] a);
        return a == addr_amp || a == addr_freq || a == addr_phase || a == addr_wave;
    endfunction

    function automatic logic [31:0] expected_read(input logic [7:0] a);
        case (a)
            addr_amp:   return m_amp;
            addr_freq:  return m_freq;
            addr_phase: return {20'd0, m_poff};
            addr_wave:  return {28'd0, m_wave};
            default:    return 32'd0;
        endcase
    endfunction

    // compare first and then step the model across the coming edge
    always @(negedge sys_clk) begin
        if (model_live) begin
            if (dac_data !== m_dac) begin
                dac_errors++;
                $display("CHECK FAILED dac_data: expected %h, got %h at %0t",
                         m_dac, dac_data, $time);
            end
            if (rsp_valid !== m_pend) begin
                bus_errors++;
                $display("CHECK FAILED rsp_valid: expected %h, got %h at %0t",
                         m_pend, rsp_valid, $time);
            end
            if (cmd_ready !== (!m_pend || rsp_ready)) begin
                bus_errors++;
                $display("CHECK FAILED cmd_ready: expected %h, got %h at %0t",
                         !m_pend || rsp_ready, cmd_ready, $time);
            end
        end
        if (!sys_rst_n) begin
            m_amp    = rst_amp;
            m_freq   = rst_freq;
            m_poff   = rst_phase[11:0];
            m_wave   = rst_wave;
            m_acc    = 32'd0;
            m_phase  = 12'd0;
            s1_phase = 12'd0;
            s1_wave  = 4'd0;  // shape 0 until stage 1 loads
            m_dac    = 8'd128;
            m_pend   = 1'b0;
        end else begin
            m_dac    = expected_code(s1_phase, s1_wave, m_amp[8:0]);  // amp at stage 2
            s1_phase = m_phase;
            s1_wave  = m_wave;
            m_phase  = m_acc[31:20] + m_poff;
            m_acc    = m_acc + m_freq;
            if (cmd_valid && (!m_pend || rsp_ready)) begin
                m_pend = 1'b1;
                if (!cmd_read) begin
                    case (cmd_addr[7:0])
                        addr_amp:   m_amp  = cmd_wdata;
                        addr_freq:  m_freq = cmd_wdata;
                        addr_phase: m_poff = cmd_wdata[11:0];
                        addr_wave:  m_wave = cmd_wdata[3:0];
                        default: ;
                    endcase
                end
            end else if (rsp_ready) begin
                m_pend = 1'b0;
            end
        end
        model_live = 1'b1;
    end

    ////////////////////////////////////////////////////////////////////////////
    // bus driver
    ////////////////////////////////////////////////////////////////////////////

    task automatic run_cycles(input int n);
        repeat (n) @(posedge sys_clk);
        #1;
    endtask

    // one command with a random stall on rsp_ready and a checked response
    task automatic bus_xfer(input logic [31:0] addr, input logic rd, input logic [31:0] wdata);
        int          stall;
        logic        done;
        logic [31:0] exp_data;
        logic        exp_err;
        stall     = $unsigned($random(seed)) % 6;
        exp_data  = rd ? expected_read(addr[7:0]) : 32'd0;
        exp_err   = !is_mapped(addr[7:0]);
        cmd_valid = 1'b1;
        cmd_addr  = addr;
        cmd_read  = rd;
        cmd_wdata = wdata;
        rsp_ready = (stall == 0);
        done      = 1'b0;
        while (!done) begin
            @(negedge sys_clk);
            done = cmd_ready;
            @(posedge sys_clk);
            #1;
        end
        if (stall > 0) begin
            cmd_read = !rd;  // next command waits behind the stalled response
            repeat (stall) @(posedge sys_clk);
            #1;
            rsp_ready = 1'b1;
        end
        cmd_valid = 1'b0;
        done = 1'b0;
        while (!done) begin
            @(negedge sys_clk);
            if (rsp_valid && rsp_ready) begin
                done = 1'b1;
                if (rsp_rdata !== exp_data) begin
                    bus_errors++;
                    $display("CHECK FAILED rsp_rdata: addr %h expected %h, got %h",
                             addr, exp_data, rsp_rdata);
                end
                if (rsp_err !== exp_err) begin
                    bus_errors++;
                    $display("CHECK FAILED rsp_err: addr %h expected %h, got %h",
                             addr, exp_err, rsp_err);
                end
            end
            @(posedge sys_clk);
            #1;
        end
    endtask

    task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
        bus_xfer(addr, 1'b0, data);
    endtask

    task automatic bus_read(input logic [31:0] addr);
        bus_xfer(addr, 1'b1, 32'd0);
    endtask

    task automatic read_all_regs();
        bus_read({24'd0, addr_amp});
        bus_read({24'd0, addr_freq});
        bus_read({24'd0, addr_phase});
        bus_read({24'd0, addr_wave});
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge sys_clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("timeout: test did not finish");
            $display("TB FAILED");
            $finish;
        end
    end

    initial begin
        seed       = 32'h42d5;
        sys_clk    = 1'b0;
        sys_rst_n  = 1'b0;
        cmd_valid  = 1'b0;
        cmd_read   = 1'b0;
        cmd_addr   = 32'd0;
        cmd_wdata  = 32'd0;
        rsp_ready  = 1'b1;
        dac_errors = 0;
        bus_errors = 0;
        cycles     = 0;
        model_live = 1'b0;
        repeat (16) @(posedge sys_clk);
        #1;
        sys_rst_n = 1'b1;

        read_all_regs();  // reset defaults and sine from acc = 0
        run_cycles(200);

        for (int r = 0; r < 4; r++) begin  // random contents under random stalls
            bus_write({24'd0, addr_amp}, $random(seed));
            bus_write({24'd0, addr_freq}, $random(seed));
            bus_write({24'd0, addr_phase}, $random(seed));
            bus_write({24'd0, addr_wave}, $random(seed));
            read_all_regs();
            run_cycles(20);
        end

        bus_write(32'h08, $random(seed));  // decode misses
        bus_write(32'h14, $random(seed));
        bus_write(32'hFC, $random(seed));
        bus_read(32'h08);
        bus_read(32'h14);
        bus_read(32'hFC);
        bus_read(32'h0000_1004);  // aliases freq through the ignored upper bits
        read_all_regs();

        bus_write({24'd0, addr_amp}, 32'd256);
        bus_write({24'd0, addr_freq}, 32'h0123_4567);  // ~225 cycles per turn
        bus_write({24'd0, addr_phase}, 32'd0);
        for (int w = 0; w < 4; w++) begin
            bus_write({24'd0, addr_wave}, {28'd0, wave_list[w]});
            run_cycles(600);
        end
        bus_write({24'd0, addr_wave}, 32'h3);  // not one-hot
        run_cycles(100);
        if (dac_data !== 8'd128) begin
            dac_errors++;
            $display("CHECK FAILED dac_data: expected %h, got %h", 8'd128, dac_data);
        end

        bus_write({24'd0, addr_wave}, {28'd0, wave_sine});
        for (int a = 0; a < 3; a++) begin
            bus_write({24'd0, addr_amp}, amp_steps[a]);
            run_cycles(250);
        end
        bus_write({24'd0, addr_wave}, {28'd0, wave_square});  // 511 drives both rails
        run_cycles(250);
        bus_write({24'd0, addr_wave}, {28'd0, wave_sine});
        bus_write({24'd0, addr_amp}, 32'd200);
        for (int o = 0; o < 4; o++) begin
            bus_write({24'd0, addr_phase}, phase_steps[o]);
            run_cycles(150);
        end
        read_all_regs();
        run_cycles(10);

        $display("errors: dac_data %0d, bus %0d", dac_errors, bus_errors);
        if (dac_errors + bus_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== bench/dds_top_sva.sv ====
`timescale 1ns/10ps

module dds_top_sva (
    input logic        sys_clk,
    input logic        sys_rst_n,
    input logic        cmd_ready,
    input logic        rsp_valid,
    input logic        rsp_ready,
    input logic        rsp_err,
    input logic [31:0] rsp_rdata,
    input logic [7:0]  dac_data
);

    ////////////////////////////////////////////////////////////////////////////
    // bus protocol and reset state
    ////////////////////////////////////////////////////////////////////////////

    rsp_idle_after_reset: assert property (@(posedge sys_clk) !sys_rst_n |=> !rsp_valid)
        else $error("rsp_valid high in the cycle after reset");

    // payload frozen until the host takes it
    rsp_held: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp_rdata) && $stable(rsp_err)))
        else $error("response changed while stalled");

    cmd_blocked: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        (rsp_valid && !rsp_ready) |-> !cmd_ready)
        else $error("cmd_ready high with a response pending");

    dac_mid_after_reset: assert property (@(posedge sys_clk) !sys_rst_n |=> dac_data == 8'd128)
        else $error("dac_data not mid-scale after reset");

endmodule

bind dds_top dds_top_sva i_dds_top_sva (
    .sys_clk   (sys_clk),
    .sys_rst_n (sys_rst_n),
    .cmd_ready (cmd_ready),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp_err   (rsp_err),
    .rsp_rdata (rsp_rdata),
    .dac_data  (dac_data)
);

// ==== hdl/dds_top.sv ====
`timescale 1ns/10ps

module dds_top import dds_pkg::*; #(
    parameter int phase_width = 32,  // accumulator width
    parameter int table_bits  = 12   // 10 and 14 also work
) (
    input  logic        sys_clk,
    input  logic        sys_rst_n,
    input  logic        cmd_valid,
    output logic        cmd_ready,
    input  logic [31:0] cmd_addr,
    input  logic        cmd_read,
    input  logic [31:0] cmd_wdata,
    output logic        rsp_valid,
    input  logic        rsp_ready,
    output logic        rsp_err,
    output logic [31:0] rsp_rdata,
    output logic [7:0]  dac_data
);

    logic [8:0]             amp;        // 256 = unity
    logic [phase_width-1:0] freq_word;  // tuning word
    logic [table_bits-1:0]  phase_off;
    logic [table_bits-1:0]  phase;      // accumulator to wave stage
    dds_wave_e              wave_sel;

    ////////////////////////////////////////////////////////////////////////////
    // register block, then accumulator and wave stage
    ////////////////////////////////////////////////////////////////////////////

    dds_regs #(.phase_width(phase_width), .table_bits(table_bits)) i_dds_regs (
        .sys_clk, .sys_rst_n,
        .cmd_valid, .cmd_read, .cmd_addr, .cmd_wdata, .cmd_ready,
        .rsp_valid, .rsp_err, .rsp_ready, .rsp_rdata,
        .amp, .freq_word, .phase_off, .wave_sel
    );

    dds_phase_acc #(.phase_width(phase_width), .table_bits(table_bits)) i_dds_phase_acc (
        .sys_clk, .sys_rst_n,
        .freq_word, .phase_off,
        .phase
    );

    // dac_data trails the accumulator by 3 cycles
    dds_wave_gen #(.table_bits(table_bits)) i_dds_wave_gen (
        .sys_clk, .sys_rst_n,
        .phase, .wave_sel, .amp,
        .dac_data
    );

endmodule

// ==== hdl/dds_wave_gen.sv ====
`timescale 1ns/10ps

module dds_wave_gen import dds_pkg::*; #(
    parameter int table_bits = 12
) (
    input  logic                  sys_clk,
    input  logic                  sys_rst_n,
    input  logic [table_bits-1:0] phase,
    input  dds_wave_e             wave_sel,
    input  logic [8:0]            amp,
    output logic [7:0]            dac_data
);

    logic [7:0]         p;          // top 8 phase bits as 0..255
    logic [5:0]         sin_idx;    // quarter table index
    logic [6:0]         sin_mag;
    logic [8:0]         tri_dist;   // |p - 128|
    logic signed [9:0]  tri_val;
    logic signed [9:0]  saw_val;
    logic signed [7:0]  shape_d;    // stage 1 result in -127..127
    logic signed [7:0]  shape_q;
    logic signed [17:0] prod;       // shape times amp
    logic signed [9:0]  scaled;     // prod >>> 8
    logic signed [10:0] code_wide;  // before clamp

    assign p = phase[table_bits-1 -: 8];  // lower bits dropped

    ////////////////////////////////////////////////////////////////////////////
    // stage 1 shape
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        sin_idx  = p[6] ? ~p[5:0] : p[5:0];  // mirror 2nd and 4th quadrant
        sin_mag  = quarter_sine(sin_idx);
        tri_dist = p[7] ? {2'b00, p[6:0]} : (9'd128 - {1'b0, p});
        tri_val  = 10'sd127 - $signed({tri_dist, 1'b0});  // 127 - 2*dist
        saw_val  = $signed({2'b00, p}) - 10'sd128;

        case (wave_sel)
            wave_sine: begin
                shape_d = p[7] ? -$signed({1'b0, sin_mag}) : $signed({1'b0, sin_mag});
            end
            wave_square: begin
                shape_d = p[7] ? -8'sd127 : 8'sd127;
            end
            wave_triangle: begin
                // ends reach -129
                shape_d = (tri_val < -10'sd127) ? -8'sd127 : tri_val[7:0];
            end
            wave_saw: begin
                shape_d = (saw_val < -10'sd127) ? -8'sd127 : saw_val[7:0];  // p = 0 only
            end
            default: shape_d = 8'sd0;  // mid-scale out for a code that is not one-hot
        endcase
    end

    always_ff @(posedge sys_clk) begin
        if (!sys_rst_n) begin
            shape_q <= 8'sd0;
        end else begin
            shape_q <= shape_d;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // stage 2 amplitude and offset binary
    ////////////////////////////////////////////////////////////////////////////

    // amp 256 is unity and 511 overshoots into the clamp below
    assign prod      = shape_q * $signed({1'b0, amp});
    assign scaled    = prod[17:8];              // floor toward -inf
    assign code_wide = 11'sd128 + scaled;       // -126..381

    always_ff @(posedge sys_clk) begin
        if (!sys_rst_n) begin
            dac_data <= 8'd128;  // mid-scale
        end else if (code_wide < 11'sd0) begin
            dac_data <= 8'd0;
        end else if (code_wide > 11'sd255) begin
            dac_data <= 8'd255;
        end else begin
            dac_data <= code_wide[7:0];
        end
    end

endmodule

// ==== hdl/dds_phase_acc.sv ====
`timescale 1ns/10ps

module dds_phase_acc #(
    parameter int phase_width = 32,
    parameter int table_bits  = 12
) (
    input  logic                   sys_clk,
    input  logic                   sys_rst_n,
    input  logic [phase_width-1:0] freq_word,
    input  logic [table_bits-1:0]  phase_off,
    output logic [table_bits-1:0]  phase
);

    logic [phase_width-1:0] acc;      // free running accumulator
    logic [table_bits-1:0]  acc_top;  // truncated table phase

    assign acc_top = acc[phase_width-1 -: table_bits];

    ////////////////////////////////////////////////////////////////////////////
    // accumulator and offset stage
    ////////////////////////////////////////////////////////////////////////////

    // acc(n+1) = acc(n) + freq_word(n)
    always_ff @(posedge sys_clk) begin
        if (!sys_rst_n) begin
            acc <= '0;
        end else begin
            acc <= acc + freq_word;  // modulo 2^phase_width
        end
    end

    // offset added after truncation
    // sum wraps at the table size, so no carry handling
    always_ff @(posedge sys_clk) begin
        if (!sys_rst_n) begin
            phase <= '0;
        end else begin
            phase <= acc_top + phase_off;
        end
    end

endmodule

// ==== hdl/dds_regs.sv ====
`timescale 1ns/10ps

module dds_regs import dds_pkg::*; #(
    parameter int phase_width = 32,
    parameter int table_bits  = 12
) (
    input  logic                   sys_clk,
    input  logic                   sys_rst_n,
    input  logic                   cmd_valid,
    input  logic                   cmd_read,
    input  logic [31:0]            cmd_addr,
    input  logic [31:0]            cmd_wdata,
    output logic                   cmd_ready,
    output logic                   rsp_valid,
    output logic                   rsp_err,
    input  logic                   rsp_ready,
    output logic [31:0]            rsp_rdata,
    output logic [8:0]             amp,
    output logic [phase_width-1:0] freq_word,
    output logic [table_bits-1:0]  phase_off,
    output dds_wave_e              wave_sel
);

    logic [31:0] amp_reg;   // full word kept for readback
    logic        cmd_hsk;   // command accepted this cycle
    logic        addr_hit;  // low byte matches a register
    logic [31:0] rd_word;   // selected register, zero-extended

    // a taken response frees the single slot in the same cycle
    assign cmd_ready = ~rsp_valid | rsp_ready;
    assign cmd_hsk   = cmd_valid & cmd_ready;
    assign amp       = amp_reg[8:0];  // core only needs 0..511

    ////////////////////////////////////////////////////////////////////////////
    // address decode
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        addr_hit = 1'b1;
        rd_word  = 32'd0;
        case (cmd_addr[7:0])  // upper address bits ignored
            addr_amp:   rd_word = amp_reg;
            addr_freq:  rd_word = 32'(freq_word);
            addr_phase: rd_word = 32'(phase_off);
            addr_wave:  rd_word = 32'(wave_sel);
            default:    addr_hit = 1'b0;  // 0x08 lands here too
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // control registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge sys_clk) begin
        if (!sys_rst_n) begin
            amp_reg   <= rst_amp;
            freq_word <= rst_freq[phase_width-1:0];
            phase_off <= rst_phase[table_bits-1:0];
            wave_sel  <= rst_wave;
        end else if (cmd_hsk && !cmd_read) begin
            case (cmd_addr[7:0])
                addr_amp:   amp_reg   <= cmd_wdata;
                addr_freq:  freq_word <= cmd_wdata[phase_width-1:0];
                addr_phase: phase_off <= cmd_wdata[table_bits-1:0];
                addr_wave:  wave_sel  <= dds_wave_e'(cmd_wdata[3:0]);  // any code stored
                default: ;  // miss writes nothing
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // response slot
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge sys_clk) begin
        if (!sys_rst_n) begin
            rsp_valid <= 1'b0;
        end else if (cmd_hsk) begin
            rsp_valid <= 1'b1;  // one response per read or write
        end else if (rsp_ready) begin
            rsp_valid <= 1'b0;
        end
    end

    // payload holds while the slot waits on rsp_ready
    always_ff @(posedge sys_clk) begin
        if (cmd_hsk) begin
            rsp_err   <= ~addr_hit;
            rsp_rdata <= cmd_read ? rd_word : 32'd0;  // writes answer with zero
        end
    end

endmodule

// ==== hdl/dds_pkg.sv ====
package dds_pkg;

    // one-hot waveform select codes
    typedef enum logic [3:0] {
        wave_sine     = 4'd1,
        wave_square   = 4'd2,
        wave_triangle = 4'd4,
        wave_saw      = 4'd8
    } dds_wave_e;

    // register map on the low address byte
    localparam logic [7:0] addr_amp   = 8'h00;
    localparam logic [7:0] addr_freq  = 8'h04;  // 0x08 left unmapped
    localparam logic [7:0] addr_phase = 8'h0C;
    localparam logic [7:0] addr_wave  = 8'h10;

    // register contents after reset
    localparam logic [31:0] rst_amp   = 32'd256;     // unity gain
    localparam logic [31:0] rst_freq  = 32'd42949;   // about 1e-5 of sys_clk
    localparam logic [31:0] rst_phase = 32'd1024;    // quarter turn at 12 bit phase
    localparam dds_wave_e   rst_wave  = wave_sine;

    ////////////////////////////////////////////////////////////////////////////
    // quarter wave sine table
    ////////////////////////////////////////////////////////////////////////////

    // entry i = round(127 * sin((i + 0.5) * pi / 128))
    // half-step offset keeps the mirrored quadrants free of duplicate points
    localparam logic [6:0] sine_lut [64] = '{
        7'd2,   7'd5,   7'd8,   7'd11,  7'd14,  7'd17,  7'd20,  7'd23,
        7'd26,  7'd29,  7'd32,  7'd35,  7'd38,  7'd41,  7'd44,  7'd47,
        7'd50,  7'd53,  7'd56,  7'd58,  7'd61,  7'd64,  7'd67,  7'd69,
        7'd72,  7'd74,  7'd77,  7'd79,  7'd82,  7'd84,  7'd86,  7'd89,
        7'd91,  7'd93,  7'd95,  7'd97,  7'd99,  7'd101, 7'd103, 7'd105,
        7'd106, 7'd108, 7'd110, 7'd111, 7'd113, 7'd114, 7'd115, 7'd117,
        7'd118, 7'd119, 7'd120, 7'd121, 7'd122, 7'd123, 7'd124, 7'd124,
        7'd125, 7'd125, 7'd126, 7'd126, 7'd127, 7'd127, 7'd127, 7'd127
    };

    function automatic logic [6:0] quarter_sine(input logic [5:0] idx);
        return sine_lut[idx];  // caller applies the sign
    endfunction

endpackage
